//--- fifo_ctl_top.f
+incdir+common
common/fifo_ctl_pkg.sv
logic/sync_fifo.sv
fifo_ctl/loopback_path.sv
fifo_ctl/cmd_regfile.sv
fifo_ctl/tx_arbiter.sv
fifo_ctl/fifo_ctl_top.sv
testbench/tb_fifo_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the control network testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_fifo_ctl -f fifo_ctl_top.f \
    --Mdir obj_dir -o tb_fifo_ctl > sim.log 2>&1 \
    && ./obj_dir/tb_fifo_ctl >> sim.log 2>&1 \
    || echo "Testbench failed" >> sim.log

cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

//--- testbench/tb_fifo_ctl.sv
// Control network testbench
`timescale 1ns/100ps
`include "fifo_ctl_params.svh"

module tb_fifo_ctl;

    import fifo_ctl_pkg::*;

    localparam int N_LOOP          = 32;    // Test 2 words
    localparam int N_RW            = 48;    // Test 3 random commands
    localparam int N_MIX           = 80;    // Test 5 words
    localparam int TOTAL_WORDS     = 6 + N_LOOP + N_RW + 24 + 9 + N_MIX + 2;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 1000;
    localparam int DRAIN_LIMIT     = 1000;  // Cycles to empty the expected queues
    localparam int RW_BYTES        = `FCTL_RW_BITS / 8;
    localparam logic [15:0] RO_MAGIC = `FCTL_RO_MAGIC;
    localparam logic [15:0] RW_MAGIC = `FCTL_RW_MAGIC;

    logic        clk;
    logic        rst;
    logic [63:0] i_rx_data;
    logic        i_rx_valid;
    logic [31:0] o_tx_data;
    tx_tag_e     o_tx_tag;
    logic [1:0]  o_tx_ctx;
    logic        o_tx_valid;
    logic        i_tx_ready;

    integer      seed;
    logic [31:0] rdy_rand;
    logic        stall_en;                  // Random host back-pressure
    logic [127:0] rw_model;                 // Read-write bank image
    logic [33:0] exp_loop [$];              // {ctx, data}
    logic [31:0] exp_cmd [$];
    bit          exp_exact [$];             // Clear for uptime reads
    logic [15:0] uptime_vals [$];
    string       test_name;
    int          test_err;
    int          tests_run;
    int          tests_failed;
    int          n_checks;
    int          n_errors;
    logic        prev_stall;
    logic [31:0] prev_data;
    tx_tag_e     prev_tag;
    logic [1:0]  prev_ctx;
    logic [31:0] r1;
    logic [31:0] r2;
    int          b;

    fifo_ctl_top dut_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .i_rx_data  ( i_rx_data  ),
        .i_rx_valid ( i_rx_valid ),
        .o_tx_data  ( o_tx_data  ),
        .o_tx_tag   ( o_tx_tag   ),
        .o_tx_ctx   ( o_tx_ctx   ),
        .o_tx_valid ( o_tx_valid ),
        .i_tx_ready ( i_tx_ready )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [7:0] bank_byte(input logic rw_sel, input int idx);
        logic [6:0] base;
        if (rw_sel) begin
            if (idx >= RW_BYTES) return 8'h00;  // Past the bank end
            base = 7'(idx * 8);
            return rw_model[base +: 8];
        end
        case (idx)
            0:       return RO_MAGIC[7:0];
            1:       return RO_MAGIC[15:8];
            4:       return 8'(`FCTL_RO_BITS / 8);  // Size in bytes
            8:       return `FCTL_VER_MAJOR;
            9:       return `FCTL_VER_MINOR;
            10:      return `FCTL_DEVICE_ID;
            default: return 8'h00;              // Uptime bytes not modelled
        endcase
    endfunction

    // Returns {has_response, response}, applies any write to the model
    function automatic logic [32:0] model_command(input logic [63:0] w);
        logic [15:0] addr;
        logic [15:0] mask;
        logic [15:0] value;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [6:0]  bi;
        int          idx;
        if (w[7:0] != `FCTL_MAGIC || w[9:8] != RX_CMD) return 33'd0;
        addr = w[31:16];
        if (addr[14]) return 33'd0;             // Shadow space ignored
        idx   = int'(addr[13:0]);
        mask  = {w[39:32], w[47:40]};           // Un-swap
        value = {w[55:48], w[63:56]};
        lo    = bank_byte(addr[15], idx);       // Sampled before the write
        hi    = bank_byte(addr[15], idx + 1);
        if (w[13] && addr[15]) begin
            for (int i = 0; i < 16; i++) begin
                if (mask[i] && (idx * 8 + i < `FCTL_RW_BITS)) begin
                    bi = 7'(idx * 8 + i);
                    rw_model[bi] = value[i];
                end
            end
        end
        if (w[12]) return {1'b1, addr, lo, hi};   // Byte-swapped response
        return 33'd0;
    endfunction

    function automatic logic uptime_read(input logic [63:0] w);
        int idx;
        idx = int'(w[29:16]);
        return !w[31] && (idx >= 15) && (idx < 24);  // Touches bytes 16-23
    endfunction

    function automatic logic [63:0] make_cmd(input cmd_op_e op, input logic [15:0] addr,
                                             input logic [15:0] mask, input logic [15:0] value);
        logic rd;
        logic wr;
        rd = (op == OP_READ) || (op == OP_READ_WRITE);
        wr = (op == OP_WRITE) || (op == OP_READ_WRITE);
        return {value[7:0], value[15:8], mask[7:0], mask[15:8], addr,
                2'b00, wr, rd, 2'b00, RX_CMD, `FCTL_MAGIC};
    endfunction

    // --------------------------------------------------
    // Reporting
    // --------------------------------------------------
    task automatic report_mismatch(input logic [63:0] exp, input logic [63:0] act);
        $display("[ERROR] %s: expected %h, actual %h", test_name, exp, act);
        test_err++;
        n_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("[ERROR] %s: %s", test_name, msg);
        test_err++;
        n_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
    endtask

    task automatic report_test();
        tests_run++;
        if (test_err != 0) tests_failed++;
        $display("Test %0d %-16s %s, %0d errors", tests_run, test_name,
                 (test_err == 0) ? "ok" : "FAIL", test_err);
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    // Bounds keep both receive queues well below full
    task automatic send_word(input logic [63:0] w);
        logic [32:0] rsp;
        while (exp_loop.size() >= 12 || exp_cmd.size() >= 8) begin
            @(posedge clk);
            #1;
            i_rx_valid = 1'b0;
        end
        rsp = model_command(w);
        if (rsp[32]) begin
            exp_cmd.push_back(rsp[31:0]);
            exp_exact.push_back(!uptime_read(w));
        end
        if (w[7:0] == `FCTL_MAGIC && w[9:8] == RX_LOOP) exp_loop.push_back({w[11:10], w[63:32]});
        @(posedge clk);
        #1;
        i_rx_data  = w;
        i_rx_valid = 1'b1;
    endtask

    task automatic send_cmd(input cmd_op_e op, input logic [15:0] addr,
                            input logic [15:0] mask, input logic [15:0] value);
        send_word(make_cmd(op, addr, mask, value));
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        i_rx_valid = 1'b0;
    endtask

    // Wait for every expected beat, then a quiet window for strays
    task automatic drain_outputs();
        int cycles;
        cycles = 0;
        while ((exp_loop.size() != 0 || exp_cmd.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_loop.size() != 0 || exp_cmd.size() != 0) begin
            report_failure($sformatf("%0d loopback and %0d command beats never arrived",
                                     exp_loop.size(), exp_cmd.size()));
            exp_loop.delete();
            exp_cmd.delete();
            exp_exact.delete();
        end
        repeat (10) @(posedge clk);
        #1;                                     // Back to the drive point
    endtask

    // --------------------------------------------------
    // Host ready, drawn at the edge and driven 1 ns later
    // --------------------------------------------------
    always @(posedge clk) begin
        rdy_rand = $random(seed);
        #1;
        i_tx_ready = stall_en ? (rdy_rand[1:0] != 2'b00) : 1'b1;  // About 3 in 4 ready
    end

    // --------------------------------------------------
    // Comparison at mid-cycle, all inputs settled
    // --------------------------------------------------
    task automatic check_beat();
        logic [33:0] exp_l;
        logic [31:0] exp_c;
        bit          exact;
        n_checks++;
        case (o_tx_tag)
            TAG_LOOP: begin
                if (exp_loop.size() == 0) begin
                    report_failure("loopback beat with no word pending");
                end else begin
                    exp_l = exp_loop.pop_front();
                    assert ({o_tx_ctx, o_tx_data} == exp_l)
                        else report_mismatch(64'(exp_l), 64'({o_tx_ctx, o_tx_data}));
                end
            end
            TAG_CMD: begin
                if (exp_cmd.size() == 0) begin
                    report_failure("command response with no read pending");
                end else begin
                    exp_c = exp_cmd.pop_front();
                    exact = exp_exact.pop_front();
                    if (exact) begin
                        assert ({o_tx_ctx, o_tx_data} == {2'b00, exp_c})
                            else report_mismatch(64'(exp_c), 64'({o_tx_ctx, o_tx_data}));
                    end else begin
                        assert (o_tx_ctx == 2'b00 && o_tx_data[31:16] == exp_c[31:16])
                            else report_mismatch(64'(exp_c), 64'({o_tx_ctx, o_tx_data}));
                        uptime_vals.push_back({o_tx_data[7:0], o_tx_data[15:8]});
                    end
                end
            end
            default: report_failure("beat with an unknown source tag");
        endcase
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (prev_stall) begin
                n_checks++;
                assert (o_tx_valid && o_tx_data == prev_data && o_tx_tag == prev_tag &&
                        o_tx_ctx == prev_ctx)
                    else report_failure("output beat changed or dropped while stalled");
            end
            if (o_tx_valid && i_tx_ready) check_beat();
            prev_stall = o_tx_valid && !i_tx_ready;
            prev_data  = o_tx_data;
            prev_tag   = o_tx_tag;
            prev_ctx   = o_tx_ctx;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("[ERROR] watchdog expired before all tests completed");
        $display("Testbench failed");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed         = 61514;
        rst          = 1'b1;
        i_rx_data    = '0;
        i_rx_valid   = 1'b0;
        i_tx_ready   = 1'b1;
        stall_en     = 1'b0;
        prev_stall   = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        n_checks     = 0;
        n_errors     = 0;
        rw_model          = '0;
        rw_model[15:0]    = RW_MAGIC;
        rw_model[63:32]   = 32'(RW_BYTES);      // Own size in bytes
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Identity and reset values
        start_test("reset_identity");
        n_checks++;
        assert (!o_tx_valid) else report_failure("o_tx_valid high after reset");
        send_cmd(OP_READ, 16'h0000, 16'h0, 16'h0);
        send_cmd(OP_READ, 16'h0004, 16'h0, 16'h0);
        send_cmd(OP_READ, 16'h0008, 16'h0, 16'h0);
        send_cmd(OP_READ, 16'h000A, 16'h0, 16'h0);
        send_cmd(OP_READ, 16'h8000, 16'h0, 16'h0);
        send_cmd(OP_READ, 16'h8004, 16'h0, 16'h0);
        idle();
        drain_outputs();
        report_test();

        start_test("loopback_random");
        for (int i = 0; i < N_LOOP; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            send_word({r1, r2[31:10], RX_LOOP, `FCTL_MAGIC});   // Junk in spare bits
        end
        idle();
        drain_outputs();
        report_test();

        // Random ops, some past the bank end
        start_test("rw_masked");
        for (int i = 0; i < N_RW; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            b  = int'(r1[7:0]) % 20;
            send_cmd(cmd_op_e'(r1[9:8]), 16'h8000 | 16'(b), r2[15:0], r2[31:16]);
        end
        for (int i = 0; i < 20; i++) send_cmd(OP_READ, 16'h8000 | 16'(i), 16'h0, 16'h0);
        for (int i = 24; i < 28; i++) send_cmd(OP_READ, 16'(i), 16'h0, 16'h0);
        idle();
        drain_outputs();
        report_test();

        start_test("ignored_words");
        send_word({32'hDEADBEEF, 20'h0, 2'b01, RX_LOOP, 8'h76});   // Bad magic
        send_word(make_cmd(OP_WRITE, 16'h8000, 16'hFFFF, 16'h1234) ^ 64'h1);
        send_word({32'h12345678, 20'h0, 2'b10, RX_TLP, `FCTL_MAGIC});
        send_word({32'h9ABCDEF0, 20'h0, 2'b11, RX_CFG, `FCTL_MAGIC});
        send_cmd(OP_WRITE, 16'h0008, 16'hFFFF, 16'h0000);           // Read-only
        send_cmd(OP_WRITE, 16'hC000, 16'hFFFF, 16'h5555);           // Shadow
        send_cmd(OP_READ, 16'h4000, 16'h0, 16'h0);
        idle();
        repeat (30) @(posedge clk);
        #1;
        send_cmd(OP_READ, 16'h8000, 16'h0, 16'h0);
        send_cmd(OP_READ, 16'h0008, 16'h0, 16'h0);
        idle();
        drain_outputs();
        report_test();

        // Both sources under random back-pressure
        start_test("mixed_stalls");
        stall_en = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            if (r1[0]) begin
                send_word({r2, r1[31:10], RX_LOOP, `FCTL_MAGIC});
            end else if (r1[1]) begin
                b = int'(r1[15:8]) % 20;
                send_cmd(cmd_op_e'(r1[3:2]), 16'h8000 | 16'(b), r2[15:0], r2[31:16]);
            end else begin
                b = int'(r1[15:8]) % 24;
                send_cmd(OP_READ, 16'(b), 16'h0, 16'h0);
            end
        end
        idle();
        drain_outputs();
        stall_en = 1'b0;
        report_test();

        start_test("uptime");
        uptime_vals.delete();
        send_cmd(OP_READ, 16'h0010, 16'h0, 16'h0);
        idle();
        repeat (40) @(posedge clk);
        send_cmd(OP_READ, 16'h0010, 16'h0, 16'h0);
        idle();
        drain_outputs();
        n_checks++;
        if (uptime_vals.size() != 2) begin
            report_failure($sformatf("got %0d uptime responses instead of 2", uptime_vals.size()));
        end else begin
            assert (uptime_vals[1] > uptime_vals[0])
                else report_failure($sformatf("uptime did not advance, %0d then %0d",
                                              uptime_vals[0], uptime_vals[1]));
        end
        report_test();

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- fifo_ctl/fifo_ctl_top.sv
// Host control network top
`timescale 1ns/100ps
`include "fifo_ctl_params.svh"

module fifo_ctl_top #(
    parameter logic [7:0] VER_MAJOR = `FCTL_VER_MAJOR,
    parameter logic [7:0] VER_MINOR = `FCTL_VER_MINOR,
    parameter logic [7:0] DEVICE_ID = `FCTL_DEVICE_ID
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`FCTL_WORD_W-1:0] i_rx_data,
    input  logic                    i_rx_valid,
    output logic [`FCTL_BEAT_W-1:0] o_tx_data,
    output fifo_ctl_pkg::tx_tag_e   o_tx_tag,
    output logic [`FCTL_CTX_W-1:0]  o_tx_ctx,
    output logic                    o_tx_valid,
    input  logic                    i_tx_ready
);

    // Path to arbiter links
    logic [`FCTL_BEAT_W-1:0] loop_beat;
    logic [`FCTL_CTX_W-1:0]  loop_ctx;
    logic                    loop_empty;
    logic                    loop_pop;
    logic [`FCTL_BEAT_W-1:0] cmd_beat;
    logic                    cmd_empty;
    logic                    cmd_pop;

    loopback_path u_loopback (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .i_rx_data  ( i_rx_data  ),
        .i_rx_valid ( i_rx_valid ),
        .o_beat     ( loop_beat  ),
        .o_ctx      ( loop_ctx   ),
        .o_empty    ( loop_empty ),
        .i_pop      ( loop_pop   )
    );

    cmd_regfile #(
        .VER_MAJOR ( VER_MAJOR ),
        .VER_MINOR ( VER_MINOR ),
        .DEVICE_ID ( DEVICE_ID )
    ) u_cmd_regfile (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .i_rx_data  ( i_rx_data  ),
        .i_rx_valid ( i_rx_valid ),
        .o_beat     ( cmd_beat   ),
        .o_empty    ( cmd_empty  ),
        .i_pop      ( cmd_pop    )
    );

    tx_arbiter u_tx_arbiter (
        .clk          ( clk        ),
        .rst          ( rst        ),
        .i_loop_beat  ( loop_beat  ),
        .i_loop_ctx   ( loop_ctx   ),
        .i_loop_empty ( loop_empty ),
        .o_loop_pop   ( loop_pop   ),
        .i_cmd_beat   ( cmd_beat   ),
        .i_cmd_empty  ( cmd_empty  ),
        .o_cmd_pop    ( cmd_pop    ),
        .o_tx_data    ( o_tx_data  ),
        .o_tx_tag     ( o_tx_tag   ),
        .o_tx_ctx     ( o_tx_ctx   ),
        .o_tx_valid   ( o_tx_valid ),
        .i_tx_ready   ( i_tx_ready )
    );

endmodule

//--- fifo_ctl/tx_arbiter.sv
// Fixed-priority transmit stage
`timescale 1ns/100ps
`include "fifo_ctl_params.svh"

module tx_arbiter (
    input  logic                    clk,
    input  logic                    rst,

    // Loopback source, highest priority
    input  logic [`FCTL_BEAT_W-1:0] i_loop_beat,
    input  logic [`FCTL_CTX_W-1:0]  i_loop_ctx,
    input  logic                    i_loop_empty,
    output logic                    o_loop_pop,

    // Command responses
    input  logic [`FCTL_BEAT_W-1:0] i_cmd_beat,
    input  logic                    i_cmd_empty,
    output logic                    o_cmd_pop,

    // Host side
    output logic [`FCTL_BEAT_W-1:0] o_tx_data,
    output fifo_ctl_pkg::tx_tag_e   o_tx_tag,
    output logic [`FCTL_CTX_W-1:0]  o_tx_ctx,
    output logic                    o_tx_valid,
    input  logic                    i_tx_ready
);

    import fifo_ctl_pkg::*;

    logic can_load;     // Output register empty or draining

    // --------------------------------------------------
    // Selection
    // --------------------------------------------------
    assign can_load   = ~o_tx_valid | i_tx_ready;
    assign o_loop_pop = can_load & ~i_loop_empty;
    assign o_cmd_pop  = can_load & i_loop_empty & ~i_cmd_empty;   // Loopback wins ties

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            o_tx_valid <= 1'b0;
        end else if (can_load) begin
            o_tx_valid <= o_loop_pop | o_cmd_pop;
        end
    end

    // Payload only moves on a load
    always_ff @(posedge clk) begin
        if (o_loop_pop) begin
            o_tx_data <= i_loop_beat;
            o_tx_tag  <= TAG_LOOP;
            o_tx_ctx  <= i_loop_ctx;
        end else if (o_cmd_pop) begin
            o_tx_data <= i_cmd_beat;
            o_tx_tag  <= TAG_CMD;
            o_tx_ctx  <= '0;            // No context on responses
        end
    end

    // Host may stall any number of cycles
    a_hold_stalled : assert property (@(posedge clk) disable iff (rst)
        (o_tx_valid && !i_tx_ready) |=>
            (o_tx_valid && $stable(o_tx_data) && $stable(o_tx_tag) && $stable(o_tx_ctx)))
        else $error("tx_arbiter output changed while stalled");

endmodule

//--- fifo_ctl/cmd_regfile.sv
// Command register engine
`timescale 1ns/100ps
`include "fifo_ctl_params.svh"

module cmd_regfile #(
    parameter logic [7:0] VER_MAJOR = `FCTL_VER_MAJOR,
    parameter logic [7:0] VER_MINOR = `FCTL_VER_MINOR,
    parameter logic [7:0] DEVICE_ID = `FCTL_DEVICE_ID
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`FCTL_WORD_W-1:0] i_rx_data,
    input  logic                    i_rx_valid,
    output logic [`FCTL_BEAT_W-1:0] o_beat,
    output logic                    o_empty,
    input  logic                    i_pop
);

    import fifo_ctl_pkg::*;

    localparam int RW_BITS = `FCTL_RW_BITS;
    localparam int RO_BITS = `FCTL_RO_BITS;
    localparam int IDX_W   = $clog2((RW_BITS > RO_BITS) ? RW_BITS : RO_BITS);
    // Magic in bytes 0-1, byte count in bytes 4-7
    localparam logic [RW_BITS-1:0] RW_INIT =
        RW_BITS'({32'(RW_BITS / 8), 16'h0000, `FCTL_RW_MAGIC});

    // Receive queue
    rx_type_e                  rx_type;
    logic                      rx_wr_en;
    logic [`FCTL_WORD_W-1:0]   rx_dout;
    logic                      rx_empty;
    logic                      cmd_pop;

    // Execute stage
    logic                      cmd_vld;
    logic [`FCTL_WORD_W-1:0]   cmd_q;
    cmd_op_e                   cmd_op;
    logic [15:0]               cmd_addr;
    logic [17:0]               cmd_bit;         // Byte address x 8
    logic [IDX_W-1:0]          cmd_idx;
    logic [15:0]               cmd_mask;
    logic [15:0]               cmd_value;
    logic                      f_rw;
    logic                      f_shadow;
    logic                      in_range;
    logic                      do_read;
    logic                      do_write;
    logic [15:0]               rd_bits;

    // Banks
    logic [RW_BITS-1:0]        rw;
    logic [RO_BITS-1:0]        ro;
    logic [RW_BITS+15:0]       rw_pad;          // Zero tail for top-byte reads
    logic [RO_BITS+15:0]       ro_pad;
    logic [63:0]               uptime;

    // Response queue
    logic                      rsp_wr;
    logic [`FCTL_BEAT_W-1:0]   rsp_din;
    logic                      rsp_almost_full;

    // --------------------------------------------------
    // Receive and throttle
    // --------------------------------------------------
    assign rx_type  = rx_type_e'(i_rx_data[`FCTL_TYPE_LSB +: 2]);
    assign rx_wr_en = i_rx_valid & (i_rx_data[7:0] == `FCTL_MAGIC) & (rx_type == RX_CMD);

    sync_fifo #(
        .WIDTH ( `FCTL_WORD_W   ),
        .DEPTH ( `FCTL_CMD_DEPTH )
    ) u_rx_fifo (
        .clk           ( clk       ),
        .rst           ( rst       ),
        .i_wr_en       ( rx_wr_en  ),
        .i_din         ( i_rx_data ),
        .i_rd_en       ( cmd_pop   ),
        .o_dout        ( rx_dout   ),
        .o_empty       ( rx_empty  ),
        .o_almost_full (           )
    );

    // Headroom of two covers the command already in the execute stage
    assign cmd_pop = ~rx_empty & ~rsp_almost_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_vld <= 1'b0;
        end else begin
            cmd_vld <= cmd_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cmd_q <= rx_dout;
        end
    end

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    assign cmd_op    = cmd_op_e'({cmd_q[`FCTL_WR_BIT], cmd_q[`FCTL_RD_BIT]});
    assign cmd_addr  = cmd_q[`FCTL_ADDR_LSB +: 16];
    assign cmd_bit   = {cmd_addr[14:0], 3'b000};
    assign cmd_idx   = cmd_bit[IDX_W-1:0];
    assign cmd_value = {cmd_q[`FCTL_VALUE_LSB +: 8], cmd_q[`FCTL_VALUE_LSB + 8 +: 8]}; // Un-swap
    assign cmd_mask  = {cmd_q[`FCTL_MASK_LSB +: 8], cmd_q[`FCTL_MASK_LSB + 8 +: 8]};
    assign f_rw      = cmd_addr[`FCTL_BANK_BIT];
    assign f_shadow  = cmd_addr[`FCTL_SHADOW_BIT];     // Not supported

    assign do_read  = cmd_vld & ~f_shadow & ((cmd_op == OP_READ) | (cmd_op == OP_READ_WRITE));
    assign do_write = cmd_vld & ~f_shadow & f_rw &
                      ((cmd_op == OP_WRITE) | (cmd_op == OP_READ_WRITE));

    // --------------------------------------------------
    // Read-only bank
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            uptime <= '0;
        end else begin
            uptime <= uptime + 64'd1;   // Cycles since reset
        end
    end

    assign ro[15:0]    = `FCTL_RO_MAGIC;        // +00
    assign ro[31:16]   = '0;
    assign ro[63:32]   = 32'(RO_BITS / 8);      // +04 byte count
    assign ro[71:64]   = VER_MAJOR;             // +08
    assign ro[79:72]   = VER_MINOR;             // +09
    assign ro[87:80]   = DEVICE_ID;             // +0A
    assign ro[127:88]  = '0;
    assign ro[191:128] = uptime;                // +10

    // --------------------------------------------------
    // Read-write bank and read mux
    // --------------------------------------------------
    assign rw_pad = {16'h0000, rw};
    assign ro_pad = {16'h0000, ro};

    assign in_range = f_rw ? (cmd_bit < 18'(RW_BITS)) : (cmd_bit < 18'(RO_BITS));
    assign rd_bits  = ~in_range ? 16'h0000 :
                      f_rw      ? rw_pad[cmd_idx +: 16] : ro_pad[cmd_idx +: 16];

    // Masked bit merge, bits past the bank end are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            rw <= RW_INIT;
        end else if (do_write) begin
            for (int i = 0; i < 16; i++) begin
                if (cmd_mask[i] && (int'(cmd_bit) + i < RW_BITS)) begin
                    rw[int'(cmd_bit) + i] <= cmd_value[i];
                end
            end
        end
    end

    // --------------------------------------------------
    // Response queue
    // --------------------------------------------------
    assign rsp_wr  = do_read;   // rd_bits sampled before the write lands
    assign rsp_din = {cmd_addr, rd_bits[7:0], rd_bits[15:8]};

    sync_fifo #(
        .WIDTH ( `FCTL_BEAT_W    ),
        .DEPTH ( `FCTL_CMD_DEPTH )
    ) u_rsp_fifo (
        .clk           ( clk             ),
        .rst           ( rst             ),
        .i_wr_en       ( rsp_wr          ),
        .i_din         ( rsp_din         ),
        .i_rd_en       ( i_pop           ),
        .o_dout        ( o_beat          ),
        .o_empty       ( o_empty         ),
        .o_almost_full ( rsp_almost_full )
    );

    // Throttle keeps a free slot for every command in flight
    a_rsp_room : assert property (@(posedge clk) disable iff (rst)
        rsp_wr |-> (u_rsp_fifo.count < $bits(u_rsp_fifo.count)'(`FCTL_CMD_DEPTH)))
        else $error("cmd_regfile response FIFO written when full");

endmodule

//--- fifo_ctl/loopback_path.sv
// Loopback return path
`timescale 1ns/100ps
`include "fifo_ctl_params.svh"

module loopback_path (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`FCTL_WORD_W-1:0] i_rx_data,
    input  logic                    i_rx_valid,
    output logic [`FCTL_BEAT_W-1:0] o_beat,
    output logic [`FCTL_CTX_W-1:0]  o_ctx,
    output logic                    o_empty,
    input  logic                    i_pop
);

    import fifo_ctl_pkg::*;

    localparam int ENTRY_W = `FCTL_CTX_W + `FCTL_BEAT_W;   // Context above data

    rx_type_e           rx_type;
    logic               magic_ok;
    logic               loop_wr_en;
    logic [ENTRY_W-1:0] loop_din;
    logic [ENTRY_W-1:0] loop_dout;

    // Word filter
    assign rx_type    = rx_type_e'(i_rx_data[`FCTL_TYPE_LSB +: 2]);
    assign magic_ok   = (i_rx_data[7:0] == `FCTL_MAGIC);
    assign loop_wr_en = i_rx_valid & magic_ok & (rx_type == RX_LOOP);

    assign loop_din = {i_rx_data[`FCTL_CTX_LSB +: `FCTL_CTX_W],
                       i_rx_data[`FCTL_DATA_LSB +: `FCTL_BEAT_W]};

    // No back-pressure toward host, depth bounds pending words
    sync_fifo #(
        .WIDTH ( ENTRY_W          ),
        .DEPTH ( `FCTL_LOOP_DEPTH )
    ) u_loop_fifo (
        .clk           ( clk        ),
        .rst           ( rst        ),
        .i_wr_en       ( loop_wr_en ),
        .i_din         ( loop_din   ),
        .i_rd_en       ( i_pop      ),
        .o_dout        ( loop_dout  ),
        .o_empty       ( o_empty    ),
        .o_almost_full (            )
    );

    assign o_beat = loop_dout[`FCTL_BEAT_W-1:0];
    assign o_ctx  = loop_dout[ENTRY_W-1 -: `FCTL_CTX_W];

endmodule

//--- logic/sync_fifo.sv
// Show-ahead synchronous FIFO
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_wr_en,
    input  logic [WIDTH-1:0] i_din,
    input  logic             i_rd_en,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_empty,
    output logic             o_almost_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];      // Payload storage
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;            // Entries held
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full          = (count == CW'(DEPTH));
    assign o_empty       = (count == '0);
    assign o_almost_full = (count >= CW'(DEPTH - 2));
    assign o_dout        = mem[rd_ptr];     // Head always visible

    assign do_rd = i_rd_en & ~o_empty;
    assign do_wr = i_wr_en & (~full | do_rd);   // Slot freed by same-cycle read

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer and consumer must respect the flags
    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        i_wr_en |-> (~full | i_rd_en))
        else $error("sync_fifo write while full");

    a_no_underflow : assert property (@(posedge clk) disable iff (rst)
        i_rd_en |-> ~o_empty)
        else $error("sync_fifo read while empty");

endmodule

//--- common/fifo_ctl_pkg.sv
// Control network shared types

package fifo_ctl_pkg;

    // --------------------------------------------------
    // Input word type, bits 9..8
    // --------------------------------------------------
    typedef enum logic [1:0] {
        RX_TLP  = 2'b00,    // Discarded
        RX_CFG  = 2'b01,    // Discarded
        RX_LOOP = 2'b10,    // Returned to host unchanged
        RX_CMD  = 2'b11     // Register file access
    } rx_type_e;

    // --------------------------------------------------
    // Source tag on output beats
    // --------------------------------------------------
    // Same code points as the input type
    typedef enum logic [1:0] {
        TAG_TLP  = 2'b00,
        TAG_CFG  = 2'b01,
        TAG_LOOP = 2'b10,
        TAG_CMD  = 2'b11
    } tx_tag_e;

    // --------------------------------------------------
    // Command operation
    // --------------------------------------------------
    // Encoded as {write bit 13, read bit 12}
    typedef enum logic [1:0] {
        OP_NONE       = 2'b00,
        OP_READ       = 2'b01,
        OP_WRITE      = 2'b10,
        OP_READ_WRITE = 2'b11   // Read returns value before write
    } cmd_op_e;

endpackage

//--- common/fifo_ctl_params.svh
// Control network parameters

`ifndef FIFO_CTL_PARAMS_SVH
`define FIFO_CTL_PARAMS_SVH

// Word and beat sizes
`define FCTL_WORD_W      64              // Host input word
`define FCTL_BEAT_W      32              // Output beat data
`define FCTL_CTX_W       2               // Context field

// Input word framing
`define FCTL_MAGIC       8'h77           // Bits 7..0 of every valid word
`define FCTL_TYPE_LSB    8               // Two-bit word type
`define FCTL_CTX_LSB     10              // Loopback context
`define FCTL_RD_BIT      12              // Command read flag
`define FCTL_WR_BIT      13              // Command write flag
`define FCTL_ADDR_LSB    16              // Command byte address, 16 bits
`define FCTL_DATA_LSB    32              // Loopback data, 32 bits
`define FCTL_MASK_LSB    32              // Command mask, bytes swapped
`define FCTL_VALUE_LSB   48              // Command value, bytes swapped

// Address bits inside the 16-bit byte address
`define FCTL_BANK_BIT    15              // 1 selects the read-write bank
`define FCTL_SHADOW_BIT  14              // Shadow space, ignored

// Register banks
`define FCTL_RW_BITS     128
`define FCTL_RO_BITS     192
`define FCTL_RW_MAGIC    16'hEFCD
`define FCTL_RO_MAGIC    16'hAB89

// Queue depths
`define FCTL_LOOP_DEPTH  16
`define FCTL_CMD_DEPTH   16

// Default identity
`define FCTL_VER_MAJOR   8'h04
`define FCTL_VER_MINOR   8'h02
`define FCTL_DEVICE_ID   8'h11

`endif
